// ==== hdl/plot_geom_pkg.sv ====
`default_nettype none

package plot_geom_pkg;

    //////////////////////////////////////////////////
    // Memory words and addresses.
    //////////////////////////////////////////////////
    typedef logic [15:0] word_t;  // One RGB565 pixel or ring field.
    typedef logic [9:0]  addr_t;  // Word address into the 1K RAM.

    localparam int MEM_WORDS = 1024;
    localparam int BURST_LEN = 4;  // Words per burst.

    // Four words moved by one request, word 0 at addr.
    typedef logic [0:BURST_LEN-1][15:0] burst_t;

    //////////////////////////////////////////////////
    // Screen geometry, shrunk to a narrow stride.
    //////////////////////////////////////////////////
    localparam int LINE_STRIDE = 32;  // Words per screen line.
    localparam int PLOT_BASE   = 32;  // Screen line 1, first plot row.
    localparam int X_START     = 4;   // First bar column, burst aligned.
    localparam int X_END       = 20;  // Clip column and last burst start.

    // Ring of history slots.
    // Slot layout: count, total[23:16], total[15:8], total[7:0].
    localparam int RING_BASE = 768;

endpackage

`default_nettype wire

// ==== hdl/rgb565_color_pkg.sv ====
`default_nettype none

package rgb565_color_pkg;

    // RGB565 is 5 bits red, 6 bits green, 5 bits blue.
    localparam logic [15:0] BAR_COLOR  = 16'hFE19;  // Pink bar.
    localparam logic [15:0] BG_COLOR   = 16'h0000;  // Black background.
    localparam logic [15:0] MARK_COLOR = 16'h07E0;  // Green marker.

endpackage

`default_nettype wire

// ==== hdl/burst_if.sv ====
`default_nettype none

// Four-word burst link between the engine and the RAM.
interface burst_if;

    plot_geom_pkg::addr_t  addr;    // First word of the burst.
    plot_geom_pkg::burst_t wdata;   // Write payload, word 0 first.
    plot_geom_pkg::burst_t rdata;   // Read payload, valid with done.
    logic                  rd_req;  // Level, held until done.
    logic                  wr_req;  // Level, held until done.
    logic                  done;    // One-cycle completion pulse.

    modport engine (
        output addr, wdata, rd_req, wr_req,
        input  rdata, done
    );

    modport mem (
        input  addr, wdata, rd_req, wr_req,
        output rdata, done
    );

endinterface

`default_nettype wire

// ==== hdl/burst_ram.sv ====
`default_nettype none

module burst_ram #(
    parameter int NUM_POINTS = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    burst_if.mem                      bus,
    input  wire plot_geom_pkg::addr_t scan_addr,
    output plot_geom_pkg::word_t      scan_data
);

    // End of the ring slots in use.
    localparam int MAP_END = plot_geom_pkg::RING_BASE + NUM_POINTS * plot_geom_pkg::BURST_LEN;

    plot_geom_pkg::word_t mem [0:plot_geom_pkg::MEM_WORDS-1];

    logic [1:0] step;   // Write word index, or read phase.
    logic       wr_go;
    logic       rd_go;

    // Done cycle is a gap, the engine is dropping its request.
    assign wr_go = bus.wr_req && !bus.done;
    assign rd_go = bus.rd_req && !bus.done;

    //////////////////////////////////////////////////
    // Burst sequencing.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step     <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (wr_go) begin
                if (step == 2'(plot_geom_pkg::BURST_LEN - 1)) begin
                    step     <= '0;
                    bus.done <= 1'b1;  // Last word written.
                end else begin
                    step <= step + 2'd1;
                end
            end else if (rd_go) begin
                if (step != 2'd0) begin
                    step     <= '0;
                    bus.done <= 1'b1;  // rdata lands with done.
                end else begin
                    step <= 2'd1;
                end
            end
        end
    end

    // Storage and data paths.
    always_ff @(posedge clk) begin
        if (wr_go)
            mem[bus.addr + plot_geom_pkg::addr_t'(step)] <= bus.wdata[step];  // One word per cycle.
        if (rd_go && step != 2'd0) begin
            for (int i = 0; i < plot_geom_pkg::BURST_LEN; i++)
                bus.rdata[i] <= mem[bus.addr + plot_geom_pkg::addr_t'(i)];
        end
        scan_data <= mem[scan_addr];  // Second port, never stalls.
    end

    // Engine must hold the address for the whole burst.
    assert property (@(posedge clk) disable iff (!rst_n)
        (bus.rd_req || bus.wr_req) && !bus.done |=> $stable(bus.addr));

    // Ring writes stay inside the slots of this history depth.
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr_req && int'(bus.addr) >= plot_geom_pkg::RING_BASE
        |-> int'(bus.addr) + plot_geom_pkg::BURST_LEN <= MAP_END);

endmodule

`default_nettype wire

// ==== hdl/bar_scaler.sv ====
`default_nettype none

module bar_scaler (
    input  wire plot_geom_pkg::word_t count,
    input  wire logic [1:0]           gain_shift,
    output plot_geom_pkg::addr_t      bar_end,
    output logic                      marker_ok
);

    logic [16:0] scaled;  // One spare bit so the offset cannot wrap.

    // Gain is a divide by 1, 2, 4 or 8.
    assign scaled = 17'(plot_geom_pkg::X_START) + 17'(count >> gain_shift);

    //////////////////////////////////////////////////
    // Clip at the right edge of the plot.
    //////////////////////////////////////////////////
    always_comb begin
        if (scaled >= 17'(plot_geom_pkg::X_END)) begin
            bar_end   = plot_geom_pkg::addr_t'(plot_geom_pkg::X_END);  // Full row.
            marker_ok = 1'b0;  // No room for a marker.
        end else begin
            bar_end   = plot_geom_pkg::addr_t'(scaled);
            marker_ok = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/peak_tracker.sv ====
`default_nettype none

module peak_tracker (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        clear,
    input  wire logic        update,
    input  wire logic        publish,
    input  wire logic [23:0] total,
    output logic      [23:0] max_total,
    output logic      [23:0] min_total
);

    logic [23:0] run_max;  // Over the current redraw.
    logic [23:0] run_min;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_max   <= '0;
            run_min   <= '1;
            max_total <= '0;
            min_total <= '1;
        end else begin
            if (clear) begin
                run_max <= '0;  // Fresh window each redraw.
                run_min <= '1;
            end else if (update) begin
                if (total > run_max)
                    run_max <= total;
                if (total < run_min)
                    run_min <= total;
            end
            if (publish) begin
                max_total <= run_max;  // Outputs move only at frame end.
                min_total <= run_min;
            end
        end
    end

    // One history read per strobe, never on the clearing cycle.
    assert property (@(posedge clk) disable iff (!rst_n) !(clear && update));

endmodule

`default_nettype wire

// ==== hdl/scroll_plot_engine.sv ====
`default_nettype none

module scroll_plot_engine #(
    parameter int NUM_POINTS = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 en,
    input  wire logic                 sample_valid,
    input  wire plot_geom_pkg::word_t sample_count,
    input  wire logic [23:0]          sample_total,
    burst_if.engine                   bus,
    output plot_geom_pkg::word_t      count_q,
    input  wire plot_geom_pkg::addr_t bar_end,
    input  wire logic                 marker_ok,
    output logic                      trk_clear,
    output logic                      trk_update,
    output logic                      trk_publish,
    output logic      [23:0]          trk_total,
    output logic                      frame_done
);

    localparam int SW = (NUM_POINTS > 1) ? $clog2(NUM_POINTS) : 1;

    typedef logic [SW-1:0] slot_t;

    typedef enum logic [3:0] {
        S_CLR, S_START, S_READ, S_SCALE, S_ROW, S_MARK, S_DONE, S_IDLE, S_INSERT
    } state_t;

    state_t               state;
    slot_t                rd_ptr;       // Oldest slot, drawn in the top row.
    slot_t                row;          // Row, or slot while clearing.
    plot_geom_pkg::addr_t row_base;     // First word of the current row.
    plot_geom_pkg::addr_t x;            // Current burst column.
    plot_geom_pkg::addr_t bar_q;        // Bar end of the current row.
    logic                 mark_q;
    logic                 have_sample;  // No marker before the first sample.
    logic                 pending;      // Strobe waiting for the next redraw.
    logic                 busy;
    plot_geom_pkg::word_t cnt_lat;
    logic [23:0]          tot_lat;

    assign busy = bus.rd_req || bus.wr_req;

    function automatic plot_geom_pkg::addr_t slot_addr(input slot_t s);
        return plot_geom_pkg::addr_t'(plot_geom_pkg::RING_BASE
                                      + int'(s) * plot_geom_pkg::BURST_LEN);
    endfunction

    function automatic plot_geom_pkg::burst_t fill(input plot_geom_pkg::word_t c);
        return {plot_geom_pkg::BURST_LEN{c}};
    endfunction

    // Latest strobe wins.
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            cnt_lat <= sample_count;
            tot_lat <= sample_total;
        end
    end

    //////////////////////////////////////////////////
    // Main sequencer.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_CLR;
            rd_ptr      <= '0;
            row         <= '0;
            row_base    <= plot_geom_pkg::addr_t'(plot_geom_pkg::PLOT_BASE);
            x           <= plot_geom_pkg::addr_t'(plot_geom_pkg::X_START);
            bar_q       <= '0;
            mark_q      <= 1'b0;
            have_sample <= 1'b0;
            pending     <= 1'b0;
            bus.addr    <= '0;
            bus.wdata   <= '0;
            bus.rd_req  <= 1'b0;
            bus.wr_req  <= 1'b0;
            count_q     <= '0;
            trk_clear   <= 1'b0;
            trk_update  <= 1'b0;
            trk_publish <= 1'b0;
            trk_total   <= '0;
            frame_done  <= 1'b0;
        end else begin
            trk_clear   <= 1'b0;
            trk_update  <= 1'b0;
            trk_publish <= 1'b0;
            frame_done  <= trk_publish;  // Tracker outputs are settled by now.
            // A burst in flight always runs to done.
            if (en || busy) begin
                case (state)
                    S_CLR: begin  // Zero every ring slot.
                        if (!busy) begin
                            bus.addr   <= slot_addr(row);
                            bus.wdata  <= '0;
                            bus.wr_req <= 1'b1;
                        end else if (bus.done) begin
                            bus.wr_req <= 1'b0;
                            row        <= row + 1'b1;
                            if (row == slot_t'(NUM_POINTS - 1)) begin
                                row   <= '0;
                                state <= S_START;  // Redraw of zeros paints the background.
                            end
                        end
                    end
                    S_START: begin
                        trk_clear <= 1'b1;
                        row       <= '0;
                        row_base  <= plot_geom_pkg::addr_t'(plot_geom_pkg::PLOT_BASE);
                        state     <= S_READ;
                    end
                    S_READ: begin  // Fetch the slot shown in this row.
                        if (!busy) begin
                            bus.addr   <= slot_addr(slot_t'(rd_ptr + row));
                            bus.rd_req <= 1'b1;
                        end else if (bus.done) begin
                            bus.rd_req <= 1'b0;
                            count_q    <= bus.rdata[0];
                            trk_total  <= {bus.rdata[1][7:0], bus.rdata[2][7:0],
                                           bus.rdata[3][7:0]};
                            trk_update <= 1'b1;
                            state      <= S_SCALE;
                        end
                    end
                    S_SCALE: begin  // Scaler output settles off count_q.
                        bar_q  <= bar_end;
                        mark_q <= marker_ok;
                        x      <= plot_geom_pkg::addr_t'(plot_geom_pkg::X_START);
                        state  <= S_ROW;
                    end
                    S_ROW: begin  // Five bursts across the row.
                        if (!busy) begin
                            bus.addr   <= row_base + x;
                            bus.wdata  <= fill((x + plot_geom_pkg::addr_t'(3) <= bar_q) ?
                                               rgb565_color_pkg::BAR_COLOR :
                                               rgb565_color_pkg::BG_COLOR);
                            bus.wr_req <= 1'b1;
                        end else if (bus.done) begin
                            bus.wr_req <= 1'b0;
                            if (x != plot_geom_pkg::addr_t'(plot_geom_pkg::X_END)) begin
                                x <= x + plot_geom_pkg::addr_t'(plot_geom_pkg::BURST_LEN);
                            end else if (row != slot_t'(NUM_POINTS - 1)) begin
                                row      <= row + 1'b1;
                                row_base <= row_base +
                                            plot_geom_pkg::addr_t'(plot_geom_pkg::LINE_STRIDE);
                                state    <= S_READ;
                            end else begin
                                // Bottom row is the newest; its bar sets the marker.
                                row      <= '0;
                                row_base <= plot_geom_pkg::addr_t'(plot_geom_pkg::PLOT_BASE);
                                state    <= (mark_q && have_sample) ? S_MARK : S_DONE;
                            end
                        end
                    end
                    S_MARK: begin  // Marker column down to the newest row.
                        if (!busy) begin
                            bus.addr   <= row_base + bar_q;
                            bus.wdata  <= {rgb565_color_pkg::MARK_COLOR, rgb565_color_pkg::BG_COLOR,
                                           rgb565_color_pkg::BG_COLOR, rgb565_color_pkg::BG_COLOR};
                            bus.wr_req <= 1'b1;
                        end else if (bus.done) begin
                            bus.wr_req <= 1'b0;
                            row        <= row + 1'b1;
                            row_base   <= row_base +
                                          plot_geom_pkg::addr_t'(plot_geom_pkg::LINE_STRIDE);
                            if (row == slot_t'(NUM_POINTS - 1))
                                state <= S_DONE;
                        end
                    end
                    S_DONE: begin
                        trk_publish <= 1'b1;  // frame_done one cycle later.
                        state       <= S_IDLE;
                    end
                    S_IDLE: begin
                        if (pending) begin  // Newest takes the oldest slot.
                            pending    <= 1'b0;
                            bus.addr   <= slot_addr(rd_ptr);
                            bus.wdata  <= {cnt_lat, {8'h00, tot_lat[23:16]},
                                           {8'h00, tot_lat[15:8]}, {8'h00, tot_lat[7:0]}};
                            bus.wr_req <= 1'b1;
                            state      <= S_INSERT;
                        end
                    end
                    S_INSERT: begin
                        if (bus.done) begin
                            bus.wr_req  <= 1'b0;
                            rd_ptr      <= rd_ptr + 1'b1;  // Newest now just before rd_ptr.
                            have_sample <= 1'b1;
                            state       <= S_START;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
            if (sample_valid)
                pending <= 1'b1;  // Overrides the take in S_IDLE.
        end
    end

    // The RAM serves one direction per burst.
    assert property (@(posedge clk) disable iff (!rst_n) !(bus.rd_req && bus.wr_req));

endmodule

`default_nettype wire

// ==== hdl/plot_subsys_top.sv ====
`default_nettype none

module plot_subsys_top #(
    parameter int NUM_POINTS = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 en,
    input  wire logic                 sample_valid,
    input  wire logic [15:0]          sample_count,
    input  wire logic [23:0]          sample_total,
    input  wire logic [1:0]           gain_shift,
    output logic      [23:0]          max_total,
    output logic      [23:0]          min_total,
    output logic                      frame_done,
    input  wire plot_geom_pkg::addr_t scan_addr,
    output plot_geom_pkg::word_t      scan_data
);

    burst_if bus ();

    plot_geom_pkg::word_t count_q;     // Count of the row being drawn.
    plot_geom_pkg::addr_t bar_end;
    logic                 marker_ok;
    logic                 trk_clear;
    logic                 trk_update;
    logic                 trk_publish;
    logic [23:0]          trk_total;

    //////////////////////////////////////////////////
    // Draw engine and its helpers.
    //////////////////////////////////////////////////
    scroll_plot_engine #(
        .NUM_POINTS (NUM_POINTS)
    ) i_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .sample_valid (sample_valid),
        .sample_count (sample_count),
        .sample_total (sample_total),
        .bus          (bus.engine),
        .count_q      (count_q),
        .bar_end      (bar_end),
        .marker_ok    (marker_ok),
        .trk_clear    (trk_clear),
        .trk_update   (trk_update),
        .trk_publish  (trk_publish),
        .trk_total    (trk_total),
        .frame_done   (frame_done)
    );

    bar_scaler i_scaler (
        .count      (count_q),
        .gain_shift (gain_shift),
        .bar_end    (bar_end),
        .marker_ok  (marker_ok)
    );

    peak_tracker i_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (trk_clear),
        .update    (trk_update),
        .publish   (trk_publish),
        .total     (trk_total),
        .max_total (max_total),
        .min_total (min_total)
    );

    // Frame and ring memory.
    burst_ram #(
        .NUM_POINTS (NUM_POINTS)
    ) i_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.mem),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

endmodule

`default_nettype wire

// ==== dv/plot_checker.sv ====
`default_nettype none

module plot_checker #(
    parameter int NUM_POINTS = 8
) (
    input  wire logic                 clk,
    input  wire logic                 sample_valid,
    input  wire logic [15:0]          sample_count,
    input  wire logic [23:0]          sample_total,
    input  wire logic [1:0]           gain_shift,
    input  wire logic                 frame_done,
    input  wire logic [23:0]          max_total,
    input  wire logic [23:0]          min_total,
    input  wire logic [8*12-1:0]      test_name,
    input  wire plot_geom_pkg::word_t scan_data,
    output plot_geom_pkg::addr_t      scan_addr,
    output int                        frames_checked,
    output int                        tests_run,
    output int                        tests_failed
);
    timeunit 1ns;
    timeprecision 100ps;

    // Words per plot row, X_START up to the end of the last burst.
    localparam int ROW_WORDS = plot_geom_pkg::X_END + plot_geom_pkg::BURST_LEN
                               - plot_geom_pkg::X_START;

    logic [15:0] hist_cnt [NUM_POINTS];  // Index 0 is the top row.
    logic [23:0] hist_tot [NUM_POINTS];
    logic        have_sample;
    logic        busy;                   // Redraw in flight.
    logic        pending;                // Strobe held for the next redraw.
    logic [15:0] pend_cnt;
    logic [23:0] pend_tot;
    logic [1:0]  gain_q;                 // Gain of the frame under check.
    logic        test_err;
    string       fail_what;
    logic [23:0] fail_exp;
    logic [23:0] fail_act;

    // Unclipped bar end column.
    function automatic int raw_end(input logic [15:0] cnt, input logic [1:0] g);
        return plot_geom_pkg::X_START + int'(cnt >> g);
    endfunction

    function automatic logic [15:0] expected_word(input int r, input int c);
        int          bar;
        int          mark;
        logic [15:0] w;
        bar  = raw_end(hist_cnt[r], gain_q);
        mark = raw_end(hist_cnt[NUM_POINTS-1], gain_q);  // Newest row sets the marker.
        if (bar > plot_geom_pkg::X_END)
            bar = plot_geom_pkg::X_END;
        w = (c - (c % plot_geom_pkg::BURST_LEN) + 3 <= bar) ? rgb565_color_pkg::BAR_COLOR
                                                            : rgb565_color_pkg::BG_COLOR;
        if (have_sample && mark < plot_geom_pkg::X_END) begin
            if (c == mark)
                w = rgb565_color_pkg::MARK_COLOR;
            else if (c > mark && c <= mark + 3)
                w = rgb565_color_pkg::BG_COLOR;  // Tail of the marker burst.
        end
        return w;
    endfunction

    task automatic insert(input logic [15:0] cnt, input logic [23:0] tot);
        for (int i = 0; i < NUM_POINTS - 1; i++) begin
            hist_cnt[i] = hist_cnt[i+1];  // Scroll up one row.
            hist_tot[i] = hist_tot[i+1];
        end
        hist_cnt[NUM_POINTS-1] = cnt;
        hist_tot[NUM_POINTS-1] = tot;
        have_sample = 1'b1;
    endtask

    // Keeps only the first mismatch of a test.
    task automatic compare(input string what, input logic [23:0] exp, input logic [23:0] act);
        if (exp !== act && !test_err) begin
            test_err  = 1'b1;
            fail_what = what;
            fail_exp  = exp;
            fail_act  = act;
        end
    endtask

    task automatic check_peaks();
        logic [23:0] mx;
        logic [23:0] mn;
        mx = '0;
        mn = '1;
        for (int i = 0; i < NUM_POINTS; i++) begin
            if (hist_tot[i] > mx) mx = hist_tot[i];
            if (hist_tot[i] < mn) mn = hist_tot[i];
        end
        compare("max_total", mx, max_total);
        compare("min_total", mn, min_total);
    endtask

    //////////////////////////////////////////////////
    // Frame readback over the scan port.
    //////////////////////////////////////////////////
    task automatic read_frame();
        int r;
        int c;
        for (int i = 0; i <= NUM_POINTS * ROW_WORDS; i++) begin
            @(posedge clk);
            #1;
            if (i < NUM_POINTS * ROW_WORDS)
                scan_addr = plot_geom_pkg::addr_t'(plot_geom_pkg::PLOT_BASE
                            + (i / ROW_WORDS) * plot_geom_pkg::LINE_STRIDE
                            + plot_geom_pkg::X_START + i % ROW_WORDS);
            @(negedge clk);
            if (i > 0) begin  // Data of the previous address, one cycle late.
                r = (i - 1) / ROW_WORDS;
                c = plot_geom_pkg::X_START + (i - 1) % ROW_WORDS;
                compare($sformatf("row %0d col %0d", r, c),
                        {8'h00, expected_word(r, c)}, {8'h00, scan_data});
            end
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_err) begin
            tests_failed++;
            $display("FAILED %0s: %0s expected %0h, actual %0h",
                     test_name, fail_what, fail_exp, fail_act);
        end else begin
            $display("ok     %0s", test_name);
        end
        test_err = 1'b0;
    endtask

    initial begin
        logic        sv;
        logic [15:0] cnt;
        logic [23:0] tot;
        scan_addr      = '0;
        frames_checked = 0;
        tests_run      = 0;
        tests_failed   = 0;
        busy           = 1'b1;  // Clear and first redraw follow reset.
        pending        = 1'b0;
        have_sample    = 1'b0;
        test_err       = 1'b0;
        gain_q         = '0;
        for (int i = 0; i < NUM_POINTS; i++) begin
            hist_cnt[i] = '0;
            hist_tot[i] = '0;
        end
        forever begin
            @(negedge clk);
            sv  = sample_valid;  // Taken before any readback wait.
            cnt = sample_count;
            tot = sample_total;
            if (frame_done) begin
                gain_q = gain_shift;
                check_peaks();
                if (pending) begin
                    insert(pend_cnt, pend_tot);  // Frame is redrawn at once.
                    pending = 1'b0;
                end else begin
                    busy = 1'b0;
                    read_frame();
                    finish_test();
                end
                frames_checked++;
            end
            if (sv && busy) begin
                pending  = 1'b1;  // Latest strobe wins.
                pend_cnt = cnt;
                pend_tot = tot;
            end else if (sv) begin
                insert(cnt, tot);
                busy = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/plot_tb.sv ====
`default_nettype none

module plot_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_POINTS  = 8;
    localparam int NUM_ENTRIES = 13;
    // Two extra frames for reset and coalescing, plus the ring clear.
    localparam int LIMIT = (NUM_ENTRIES + 2) * NUM_POINTS * 5 * 8 * 2 + NUM_POINTS * 8;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [15:0]     count;
        logic [23:0]     total;
        logic [1:0]      gain;
        logic            rnd;      // Count drawn at run time.
        logic [1:0]      strobes;  // Strobes sent into one redraw.
    } entry_t;

    entry_t stim [NUM_ENTRIES] = '{
        '{"gain0_short", 16'd5,     24'd1000,    2'd0, 1'b0, 2'd1},
        '{"gain1_mid",   16'd20,    24'd50,      2'd1, 1'b0, 2'd1},
        '{"gain2_mid",   16'd40,    24'h00ffff,  2'd2, 1'b0, 2'd1},
        '{"gain3_long",  16'd100,   24'd7,       2'd3, 1'b0, 2'd1},
        '{"clip_exact",  16'd16,    24'h123456,  2'd0, 1'b0, 2'd1},
        '{"clip_max",    16'hffff,  24'hfffffe,  2'd0, 1'b0, 2'd1},
        '{"rnd_gain1",   16'd0,     24'd3000,    2'd1, 1'b1, 2'd1},
        '{"edge_19",     16'd15,    24'd9,       2'd0, 1'b0, 2'd1},
        '{"rnd_gain2",   16'd0,     24'h800000,  2'd2, 1'b1, 2'd1},
        '{"zero_gain3",  16'd0,     24'd1,       2'd3, 1'b0, 2'd1},
        '{"rnd_gain0",   16'd0,     24'd77,      2'd0, 1'b1, 2'd1},
        '{"scroll_out",  16'd7,     24'd4096,    2'd1, 1'b0, 2'd1},
        '{"coalesce",    16'd9,     24'd600,     2'd0, 1'b0, 2'd3}
    };

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 en;
    logic                 sample_valid;
    logic                 frame_done;
    logic [15:0]          sample_count;
    logic [23:0]          sample_total;
    logic [23:0]          max_total;
    logic [23:0]          min_total;
    logic [1:0]           gain_shift;
    plot_geom_pkg::addr_t scan_addr;
    plot_geom_pkg::word_t scan_data;
    logic [8*12-1:0]      cur_name;
    int                   frames_checked;
    int                   tests_run;
    int                   tests_failed;
    int                   cycles = 0;
    integer               seed;

    always #4 clk = ~clk;  // 8 ns period.

    plot_subsys_top #(.NUM_POINTS (NUM_POINTS)) i_dut (
        .clk (clk), .rst_n (rst_n), .en (en), .sample_valid (sample_valid),
        .sample_count (sample_count), .sample_total (sample_total), .gain_shift (gain_shift),
        .max_total (max_total), .min_total (min_total), .frame_done (frame_done),
        .scan_addr (scan_addr), .scan_data (scan_data)
    );

    plot_checker #(.NUM_POINTS (NUM_POINTS)) i_checker (
        .clk (clk), .sample_valid (sample_valid), .sample_count (sample_count),
        .sample_total (sample_total), .gain_shift (gain_shift), .frame_done (frame_done),
        .max_total (max_total), .min_total (min_total), .test_name (cur_name),
        .scan_data (scan_data), .scan_addr (scan_addr), .frames_checked (frames_checked),
        .tests_run (tests_run), .tests_failed (tests_failed)
    );

    // One-cycle strobe 1 ns after the edge.
    task automatic send_sample(input logic [15:0] cnt, input logic [23:0] tot,
                               input logic [1:0] gain);
        @(posedge clk);
        #1;
        sample_valid = 1'b1;
        sample_count = cnt;
        sample_total = tot;
        gain_shift   = gain;
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    // Checker counts a frame_done once its compare is over.
    task automatic wait_frames(input int target);
        while (frames_checked < target)
            @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: no frame_done after %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd_val;
        logic [15:0] cnt;
        int          target;
        rst_n        = 1'b0;
        en           = 1'b1;
        sample_valid = 1'b0;
        sample_count = '0;
        sample_total = '0;
        gain_shift   = '0;
        cur_name     = "reset_clear";
        seed         = 32'ha5a9;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        target = 1;
        wait_frames(target);  // Clear frame.
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            cur_name = stim[e].name;
            cnt      = stim[e].count;
            if (stim[e].rnd) begin
                rnd_val = $random(seed);
                cnt     = rnd_val[15:0] & 16'h003f;
            end
            for (int k = 0; k < int'(stim[e].strobes); k++) begin
                if (k > 0)
                    repeat (14) @(posedge clk);  // Lands inside the running redraw.
                send_sample(cnt + 16'(3 * k), stim[e].total + 24'(k), stim[e].gain);
            end
            target += (stim[e].strobes > 2'd1) ? 2 : 1;
            wait_frames(target);
        end
        $display("Tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0 && tests_run == NUM_ENTRIES + 1) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/plot_geom_pkg.sv
hdl/rgb565_color_pkg.sv
hdl/burst_if.sv
hdl/burst_ram.sv
hdl/bar_scaler.sv
hdl/peak_tracker.sv
hdl/scroll_plot_engine.sv
hdl/plot_subsys_top.sv
dv/plot_checker.sv
dv/plot_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the plot subsystem simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module plot_tb \
    -f filelist.f \
    --Mdir obj_dir -o plot_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/plot_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
